/* net_pkg.sv */
package net_pkg;

  // rmii interface
  localparam int dibit_w = 2;

  // local host
  localparam logic [31:0] my_ip = 32'h12_12_6b_0d;

  localparam logic [15:0] ethertype_ipv4 = 16'h0800;
  localparam logic [7:0] proto_udp = 8'd17;

  // payload store, 16-bit words
  localparam int store_words = 256;
  localparam int store_aw = $clog2(store_words);

  localparam logic [31:0] crc_poly = 32'hedb8_8320;  // 04c11db7 bit-reversed
  localparam logic [31:0] crc_residue = 32'hdebb_20e3;  // register after data + fcs

  typedef struct packed {
    logic [7:0] data;
    logic valid;
  } byte_beat_t;

  typedef struct packed {
    logic [31:0] src_ip;
    logic [31:0] dst_ip;
    logic [7:0] protocol;
    logic [15:0] total_len;
  } ip_hdr_t;

  typedef struct packed {
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [15:0] length;
  } udp_hdr_t;

  typedef enum logic [2:0] {dst_mac, src_mac, ethertype, body, drop} eth_state_e;

  typedef enum logic [1:0] {header, payload, idle} ip_state_e;

  typedef enum logic {fill, read} store_state_e;

endpackage

/* rmii_byte_rx.sv */
`timescale 1ns/1ps

module rmii_byte_rx (
  input logic clk,
  input logic rst,
  input logic [net_pkg::dibit_w-1:0] rxd,
  input logic crsdv,
  output net_pkg::byte_beat_t beat
);

  logic locked;  // past the delimiter
  logic pre_seen;  // at least one 01 preamble dibit
  logic [1:0] cnt;
  logic [7:0] sh;

  always_ff @(posedge clk) begin
    if (rst) begin
      locked <= 1'b0;
      pre_seen <= 1'b0;
      cnt <= '0;
      beat.valid <= 1'b0;
    end else begin
      beat.valid <= 1'b0;
      if (!crsdv) begin
        // carrier gone, hunt again
        locked <= 1'b0;
        pre_seen <= 1'b0;
        cnt <= '0;
      end else if (!locked) begin
        if (rxd == 2'b01) begin
          pre_seen <= 1'b1;
        end else if (rxd == 2'b11 && pre_seen) begin
          locked <= 1'b1;  // 0xd5 delimiter ends in 11
          cnt <= '0;
        end else begin
          pre_seen <= 1'b0;
        end
      end else begin
        sh <= {rxd, sh[7:2]};  // lsb dibit arrives first
        cnt <= cnt + 2'd1;
        if (cnt == 2'd3) begin
          beat.valid <= 1'b1;
          beat.data <= {rxd, sh[7:2]};
        end
      end
    end
  end

endmodule

/* crc32.sv */
`timescale 1ns/1ps

module crc32 (
  input logic clk,
  input logic rst,
  input logic start,
  input net_pkg::byte_beat_t beat,
  output logic crc_ok
);
  import net_pkg::*;

  logic [31:0] crc;

  // one byte through the reflected register, lsb first
  function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] d);
    logic [31:0] r;
    r = c ^ {24'h0, d};
    for (int i = 0; i < 8; i++) begin
      r = r[0] ? ((r >> 1) ^ crc_poly) : (r >> 1);
    end
    return r;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      crc <= '1;
    end else if (beat.valid) begin
      crc <= crc_byte(crc, beat.data);
    end else if (start) begin
      crc <= '1;  // preset for next frame
    end
  end

  assign crc_ok = (crc == crc_residue);

endmodule

/* eth_rx.sv */
`timescale 1ns/1ps

module eth_rx (
  input logic clk,
  input logic rst,
  input net_pkg::byte_beat_t beat_in,
  input logic crsdv,
  input logic [47:0] mac,
  output net_pkg::byte_beat_t beat_out,
  output logic ip_sel,
  output logic frame_done,
  output logic fcs_ok
);
  import net_pkg::*;

  eth_state_e state;
  logic [2:0] cnt;
  logic uni_ok, bc_ok;
  logic [15:0] eth_type;
  logic crsdv_q, fall_q;
  logic crc_ok;
  logic [7:0] mac_byte;
  logic uni_nx, bc_nx;

  crc32 u_crc (
    .clk(clk),
    .rst(rst),
    .start(frame_done),
    .beat(beat_in),
    .crc_ok(crc_ok)
  );

  // first byte on the wire is mac[47:40]
  assign mac_byte = mac[8*(5-cnt) +: 8];
  assign uni_nx = uni_ok && (beat_in.data == mac_byte);
  assign bc_nx = bc_ok && (beat_in.data == 8'hff);

  always_ff @(posedge clk) begin
    if (rst) begin
      crsdv_q <= 1'b0;
      fall_q <= 1'b0;
      frame_done <= 1'b0;
      fcs_ok <= 1'b0;
    end else begin
      crsdv_q <= crsdv;
      fall_q <= crsdv_q && !crsdv;  // end of carrier
      frame_done <= fall_q;
      if (fall_q) fcs_ok <= crc_ok;  // last fcs byte already folded in
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= dst_mac;
      cnt <= '0;
      uni_ok <= 1'b1;
      bc_ok <= 1'b1;
      ip_sel <= 1'b0;
      beat_out.valid <= 1'b0;
    end else begin
      beat_out.valid <= beat_in.valid && (state == body);
      beat_out.data <= beat_in.data;
      if (fall_q) begin
        state <= dst_mac;
        cnt <= '0;
        uni_ok <= 1'b1;
        bc_ok <= 1'b1;
        ip_sel <= 1'b0;
      end else if (beat_in.valid) begin
        case (state)
          dst_mac: begin
            uni_ok <= uni_nx;
            bc_ok <= bc_nx;
            cnt <= cnt + 3'd1;
            if (cnt == 3'd5) begin
              cnt <= '0;
              state <= (uni_nx || bc_nx) ? src_mac : drop;
            end
          end
          src_mac: begin
            cnt <= cnt + 3'd1;
            if (cnt == 3'd5) begin
              cnt <= '0;
              state <= ethertype;
            end
          end
          ethertype: begin
            eth_type <= {eth_type[7:0], beat_in.data};
            cnt <= cnt + 3'd1;
            if (cnt == 3'd1) begin
              if ({eth_type[7:0], beat_in.data} == ethertype_ipv4) begin
                state <= body;
                ip_sel <= 1'b1;
              end else begin
                state <= drop;
              end
            end
          end
          default: ;  // body and drop hold until carrier ends
        endcase
      end
    end
  end

endmodule

/* ipv4_rx.sv */
`timescale 1ns/1ps

module ipv4_rx (
  input logic clk,
  input logic rst,
  input net_pkg::byte_beat_t beat_in,
  input logic sel,
  input logic frame_done,
  output net_pkg::ip_hdr_t hdr,
  output net_pkg::byte_beat_t beat_out
);
  import net_pkg::*;

  ip_state_e state;
  logic [4:0] cnt;  // header byte index
  logic [15:0] remain;  // ip payload bytes still to pass

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= header;
      cnt <= '0;
      beat_out.valid <= 1'b0;
    end else begin
      beat_out.valid <= 1'b0;
      beat_out.data <= beat_in.data;
      if (frame_done) begin
        state <= header;
        cnt <= '0;
      end else if (beat_in.valid && sel) begin
        case (state)
          header: begin
            cnt <= cnt + 5'd1;
            case (cnt)
              5'd2: hdr.total_len[15:8] <= beat_in.data;
              5'd3: hdr.total_len[7:0] <= beat_in.data;
              5'd9: hdr.protocol <= beat_in.data;
              5'd12, 5'd13, 5'd14, 5'd15: begin
                hdr.src_ip <= {hdr.src_ip[23:0], beat_in.data};
              end
              5'd16, 5'd17, 5'd18, 5'd19: begin
                hdr.dst_ip <= {hdr.dst_ip[23:0], beat_in.data};
              end
              default: ;
            endcase
            if (cnt == 5'd19) begin
              if (hdr.total_len > 16'd20) begin
                state <= payload;
                remain <= hdr.total_len - 16'd20;
              end else begin
                state <= idle;
              end
            end
          end
          payload: begin
            // stops at total_len, so padding and fcs never go further
            beat_out.valid <= 1'b1;
            remain <= remain - 16'd1;
            if (remain == 16'd1) state <= idle;
          end
          default: ;  // idle until frame end
        endcase
      end
    end
  end

endmodule

/* udp_rx.sv */
`timescale 1ns/1ps

module udp_rx (
  input logic clk,
  input logic rst,
  input net_pkg::byte_beat_t beat_in,
  input net_pkg::ip_hdr_t hdr,
  input logic sel,
  input logic [15:0] udp_port,
  input logic frame_done,
  output net_pkg::udp_hdr_t udp,
  output net_pkg::byte_beat_t beat_out,
  output logic udp_ok
);
  import net_pkg::*;

  logic [2:0] cnt;
  logic hdr_done;

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt <= '0;
      hdr_done <= 1'b0;
      udp_ok <= 1'b0;
      beat_out.valid <= 1'b0;
    end else begin
      // payload goes on only for a frame addressed here
      beat_out.valid <= beat_in.valid && hdr_done && udp_ok;
      beat_out.data <= beat_in.data;
      if (frame_done) begin
        cnt <= '0;
        hdr_done <= 1'b0;
        udp_ok <= 1'b0;
      end else if (beat_in.valid && !hdr_done) begin
        cnt <= cnt + 3'd1;
        case (cnt)
          3'd0, 3'd1: udp.src_port <= {udp.src_port[7:0], beat_in.data};
          3'd2, 3'd3: udp.dst_port <= {udp.dst_port[7:0], beat_in.data};
          3'd4, 3'd5: udp.length <= {udp.length[7:0], beat_in.data};
          default: ;  // checksum bytes not checked
        endcase
        if (cnt == 3'd7) begin
          hdr_done <= 1'b1;
          udp_ok <= sel && (hdr.dst_ip == my_ip) && (hdr.protocol == proto_udp)
                    && (udp.dst_port == udp_port);
        end
      end
    end
  end

endmodule

/* payload_store.sv */
`timescale 1ns/1ps

module payload_store (
  input logic clk,
  input logic rst,
  input net_pkg::byte_beat_t beat_in,
  input logic frame_done,
  input logic accept,
  output logic axiov,
  output logic [15:0] axiod
);
  import net_pkg::*;

  store_state_e state;
  logic [15:0] mem [store_words];
  logic [store_aw+1:0] byte_cnt;  // reaches 2*store_words
  logic [7:0] hi;  // pending high byte
  logic ovf;
  logic tainted;  // bytes arrived during read out
  logic [store_aw:0] n_words;
  logic [store_aw-1:0] rd_ptr;
  logic full;
  logic pad, we;
  logic [15:0] wdata;

  assign full = (byte_cnt == (store_aw+2)'(2 * store_words));

  // odd last byte goes out with a zero low half
  assign pad = (state == fill) && frame_done && byte_cnt[0];
  assign we = pad || ((state == fill) && !frame_done && beat_in.valid
                      && byte_cnt[0] && !full);
  assign wdata = pad ? {hi, 8'h00} : {hi, beat_in.data};

  always_ff @(posedge clk) begin
    if (we) mem[byte_cnt[store_aw:1]] <= wdata;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= fill;
      byte_cnt <= '0;
      ovf <= 1'b0;
      tainted <= 1'b0;
      rd_ptr <= '0;
      axiov <= 1'b0;
    end else begin
      axiov <= 1'b0;
      case (state)
        fill: begin
          if (frame_done) begin
            if (accept && !ovf && !tainted && byte_cnt != '0) begin
              state <= read;
              n_words <= byte_cnt[store_aw+1:1] + byte_cnt[0];
              rd_ptr <= '0;
            end
            byte_cnt <= '0;  // drops a discarded frame too
            ovf <= 1'b0;
            tainted <= 1'b0;
          end else if (beat_in.valid) begin
            if (full) begin
              ovf <= 1'b1;
            end else begin
              if (!byte_cnt[0]) hi <= beat_in.data;
              byte_cnt <= byte_cnt + 1'b1;
            end
          end
        end
        read: begin
          axiov <= 1'b1;
          axiod <= mem[rd_ptr];
          rd_ptr <= rd_ptr + 1'b1;
          if ({1'b0, rd_ptr} + 1'b1 == n_words) state <= fill;
          // no back-pressure, a frame overlapping read out is lost
          if (frame_done) tainted <= 1'b0;
          else if (beat_in.valid) tainted <= 1'b1;
        end
        default: state <= fill;
      endcase
    end
  end

endmodule

/* network_stack_rx.sv */
`timescale 1ns/1ps

module network_stack_rx (
  input logic clk,
  input logic rst,
  input logic [net_pkg::dibit_w-1:0] rxd,
  input logic crsdv,
  input logic [47:0] mac,
  input logic [15:0] udp_port,
  output logic axiov,
  output logic [15:0] axiod
);
  import net_pkg::*;

  byte_beat_t rx_beat, eth_beat, ip_beat, udp_beat;
  ip_hdr_t ip_hdr;
  logic ip_sel, frame_done, fcs_ok, udp_ok;
  logic accept;

  // read out only for a good fcs on a frame addressed here
  assign accept = fcs_ok && udp_ok;

  rmii_byte_rx u_rmii (
    .clk(clk),
    .rst(rst),
    .rxd(rxd),
    .crsdv(crsdv),
    .beat(rx_beat)
  );

  eth_rx u_eth (
    .clk(clk),
    .rst(rst),
    .beat_in(rx_beat),
    .crsdv(crsdv),
    .mac(mac),
    .beat_out(eth_beat),
    .ip_sel(ip_sel),
    .frame_done(frame_done),
    .fcs_ok(fcs_ok)
  );

  ipv4_rx u_ip (
    .clk(clk),
    .rst(rst),
    .beat_in(eth_beat),
    .sel(ip_sel),
    .frame_done(frame_done),
    .hdr(ip_hdr),
    .beat_out(ip_beat)
  );

  udp_rx u_udp (
    .clk(clk),
    .rst(rst),
    .beat_in(ip_beat),
    .hdr(ip_hdr),
    .sel(ip_sel),
    .udp_port(udp_port),
    .frame_done(frame_done),
    .udp(),  // header kept for debug only
    .beat_out(udp_beat),
    .udp_ok(udp_ok)
  );

  payload_store u_store (
    .clk(clk),
    .rst(rst),
    .beat_in(udp_beat),
    .frame_done(frame_done),
    .accept(accept),
    .axiov(axiov),
    .axiod(axiod)
  );

endmodule

/* net_checker.sv */
`timescale 1ns/1ps

module net_checker (
  input logic clk,
  input logic rst,
  input logic axiov,
  input logic [15:0] axiod,
  output int errors
);

  logic [15:0] exp_q[$];  // words still owed by the DUT
  int test_errs;
  int n_pass;
  int n_fail;
  int n_words;

  initial begin
    errors = 0;
    test_errs = 0;
    n_pass = 0;
    n_fail = 0;
    n_words = 0;
  end

  task automatic expect_word(input logic [15:0] w);
    exp_q.push_back(w);
  endtask

  // outputs change on posedge, so look at them half a cycle later
  always @(negedge clk) begin
    logic [15:0] want;
    if (!rst && axiov) begin
      if (exp_q.size() == 0) begin
        $display("unexpected output word %h while no word was expected", axiod);
        test_errs++;
        errors++;
      end else begin
        want = exp_q.pop_front();
        n_words++;
        if (axiod !== want) begin
          $display("FAIL axiod: got %h, expected %h", axiod, want);
          test_errs++;
          errors++;
        end
      end
    end
  end

  task automatic end_test(input int idx, input string name);
    if (exp_q.size() != 0) begin
      $display("test %0d (%s): %0d expected words never came out", idx, name, exp_q.size());
      test_errs++;
      errors++;
      exp_q.delete();
    end
    if (test_errs == 0) begin
      n_pass++;
      $display("test %0d (%s): ok", idx, name);
    end else begin
      n_fail++;
      $display("test %0d (%s): %0d errors", idx, name, test_errs);
    end
    test_errs = 0;
  endtask

  task automatic report();
    $display("tests passed %0d, failed %0d, words checked %0d", n_pass, n_fail, n_words);
  endtask

endmodule

/* net_props.sv */
`timescale 1ns/1ps

module net_props (
  input logic clk,
  input logic rst,
  input logic crsdv,
  input logic axiov,
  input logic [15:0] axiod
);

  int fail_cnt = 0;  // assertion failures so far

  // output idle once reset has been seen
  a_rst_quiet: assert property (@(posedge clk) rst |=> !axiov)
    else begin
      $error("axiov high during reset");
      fail_cnt++;
    end

  // read out only happens between frames
  a_no_overlap: assert property (@(posedge clk) disable iff (rst) crsdv |-> !axiov)
    else begin
      $error("axiov high while a frame is on the wire");
      fail_cnt++;
    end

  a_data_known: assert property (@(posedge clk) disable iff (rst) axiov |-> !$isunknown(axiod))
    else begin
      $error("axiod unknown while axiov is high");
      fail_cnt++;
    end

endmodule

bind network_stack_rx net_props u_props (
  .clk(clk),
  .rst(rst),
  .crsdv(crsdv),
  .axiov(axiov),
  .axiod(axiod)
);

/* tb_network_stack.sv */
`timescale 1ns/1ps

module tb_network_stack;
  import net_pkg::*;

  typedef struct packed {
    logic [47:0] dst_mac;
    logic [15:0] eth_type;
    logic [31:0] dst_ip;
    logic [7:0] proto;
    logic [15:0] dst_port;
    logic [15:0] pay_len;
    logic bad_fcs;
    logic accept;
  } frame_row_t;

  localparam int n_rows = 12;
  localparam int gap_clks = 600;
  localparam logic [47:0] local_mac = 48'h02_00_5e_10_20_30;
  localparam logic [15:0] local_port = 16'd5001;

  logic clk = 1'b0;
  logic rst;
  logic [1:0] rxd;
  logic crsdv;
  logic [47:0] mac;
  logic [15:0] udp_port;
  logic axiov;
  logic [15:0] axiod;
  int chk_errors;

  frame_row_t rows [n_rows];
  string row_name [n_rows];
  logic [7:0] frame_bytes[$];  // dst mac through fcs
  logic [7:0] pay_bytes[$];
  int seed = 32'h2636516d;
  int cycles = 0;
  int limit = 0;

  always #20 clk = ~clk;

  network_stack_rx DUT (
    .clk(clk),
    .rst(rst),
    .rxd(rxd),
    .crsdv(crsdv),
    .mac(mac),
    .udp_port(udp_port),
    .axiov(axiov),
    .axiod(axiod)
  );

  net_checker chk (
    .clk(clk),
    .rst(rst),
    .axiov(axiov),
    .axiod(axiod),
    .errors(chk_errors)
  );

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // reflected crc-32 over frame_bytes, bit by bit
  function automatic logic [31:0] frame_crc();
    logic [31:0] c;
    logic fb;
    c = '1;
    foreach (frame_bytes[i]) begin
      for (int k = 0; k < 8; k++) begin
        fb = c[0] ^ frame_bytes[i][k];
        c = c >> 1;
        if (fb) c = c ^ 32'hedb8_8320;
      end
    end
    return c;
  endfunction

  function automatic int frame_clocks(input frame_row_t r);
    return 4 * (8 + 42 + int'(r.pay_len) + 4) + gap_clks + 8;  // preamble, headers, fcs
  endfunction

  task automatic push_be(input logic [47:0] v, input int n);
    for (int i = n - 1; i >= 0; i--) frame_bytes.push_back(v[8*i +: 8]);
  endtask

  task automatic build_frame(input frame_row_t r);
    logic [31:0] fcs;
    logic [7:0] b;
    frame_bytes.delete();
    pay_bytes.delete();
    push_be(r.dst_mac, 6);
    push_be(48'h02_00_00_00_00_01, 6);
    push_be(r.eth_type, 2);
    push_be(16'h4500, 2);  // version 4, ihl 5
    push_be(r.pay_len + 16'd28, 2);
    push_be(32'h0000_4000, 4);  // id, df
    push_be({8'h40, r.proto}, 2);
    push_be(16'h0000, 2);  // header checksum unused
    push_be(32'h0a00_0001, 4);
    push_be(r.dst_ip, 4);
    push_be(16'd1234, 2);
    push_be(r.dst_port, 2);
    push_be(r.pay_len + 16'd8, 2);
    push_be(16'h0000, 2);
    for (int i = 0; i < r.pay_len; i++) begin
      b = 8'($random(seed));
      pay_bytes.push_back(b);
      frame_bytes.push_back(b);
    end
    fcs = ~frame_crc();
    if (r.bad_fcs) fcs = fcs ^ 32'h0000_0001;
    for (int i = 0; i < 4; i++) frame_bytes.push_back(fcs[8*i +: 8]);  // lsb byte first
  endtask

  // first byte in the high half, odd tail padded with zero
  task automatic queue_expected();
    logic [15:0] w;
    for (int i = 0; i < pay_bytes.size(); i += 2) begin
      w = {pay_bytes[i], (i + 1 < pay_bytes.size()) ? pay_bytes[i+1] : 8'h00};
      chk.expect_word(w);
    end
  endtask

  task automatic drive_byte(input logic [7:0] b);
    for (int k = 0; k < 4; k++) begin
      @(negedge clk);
      crsdv = 1'b1;
      rxd = b[2*k +: 2];
    end
  endtask

  task automatic drive_frame();
    for (int i = 0; i < 7; i++) drive_byte(8'h55);
    drive_byte(8'hd5);
    foreach (frame_bytes[i]) drive_byte(frame_bytes[i]);
    @(negedge clk);
    crsdv = 1'b0;
    rxd = 2'b00;
  endtask

  initial begin
    rst = 1'b1;
    rxd = 2'b00;
    crsdv = 1'b0;
    mac = local_mac;
    udp_port = local_port;

    rows[0] = '{local_mac, ethertype_ipv4, my_ip, proto_udp, local_port, 16'd16, 1'b0, 1'b1};
    rows[1] = '{'1, ethertype_ipv4, my_ip, proto_udp, local_port, 16'd7, 1'b0, 1'b1};
    rows[2] = '{48'h02_00_5e_10_20_31, ethertype_ipv4, my_ip, proto_udp, local_port,
                16'd10, 1'b0, 1'b0};
    rows[3] = '{local_mac, 16'h86dd, my_ip, proto_udp, local_port, 16'd10, 1'b0, 1'b0};
    rows[4] = '{local_mac, ethertype_ipv4, 32'h1212_6b0e, proto_udp, local_port,
                16'd10, 1'b0, 1'b0};
    rows[5] = '{local_mac, ethertype_ipv4, my_ip, 8'd6, local_port, 16'd10, 1'b0, 1'b0};
    rows[6] = '{local_mac, ethertype_ipv4, my_ip, proto_udp, 16'd5002, 16'd10, 1'b0, 1'b0};
    rows[7] = '{local_mac, ethertype_ipv4, my_ip, proto_udp, local_port, 16'd12, 1'b1, 1'b0};
    rows[8] = '{local_mac, ethertype_ipv4, my_ip, proto_udp, local_port, 16'd20, 1'b0, 1'b1};
    rows[9] = '{local_mac, ethertype_ipv4, my_ip, proto_udp, local_port, 16'd514, 1'b0, 1'b0};
    rows[10] = '{local_mac, ethertype_ipv4, my_ip, proto_udp, local_port, 16'd512, 1'b0, 1'b1};
    rows[11] = '{local_mac, ethertype_ipv4, my_ip, proto_udp, local_port, 16'd1, 1'b0, 1'b1};
    row_name[0] = "unicast even payload";
    row_name[1] = "broadcast odd payload";
    row_name[2] = "wrong mac";
    row_name[3] = "wrong ethertype";
    row_name[4] = "wrong dest ip";
    row_name[5] = "tcp protocol";
    row_name[6] = "wrong port";
    row_name[7] = "corrupted fcs";
    row_name[8] = "good frame after bad fcs";
    row_name[9] = "oversize payload";
    row_name[10] = "full store";
    row_name[11] = "single byte payload";

    limit = 1000 + 10;
    foreach (rows[i]) limit += frame_clocks(rows[i]);

    repeat (10) @(negedge clk);
    rst = 1'b0;
    repeat (5) @(negedge clk);

    for (int i = 0; i < n_rows; i++) begin
      build_frame(rows[i]);
      if (rows[i].accept) queue_expected();
      drive_frame();
      repeat (gap_clks) @(negedge clk);  // read out ends well inside the gap
      chk.end_test(i, row_name[i]);
    end

    chk.report();
    if (chk_errors == 0 && DUT.u_props.fail_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* list.f */
net_pkg.sv
rmii_byte_rx.sv
crc32.sv
eth_rx.sv
ipv4_rx.sv
udp_rx.sv
payload_store.sv
network_stack_rx.sv
net_checker.sv
net_props.sv
tb_network_stack.sv
